/* flist.f */
src/mem_region_pkg.sv
src/lsu_req_decoder.sv
src/mem_bank.sv
src/apb_bank_bridge.sv
src/lsu_resp_merger.sv
src/mem_region_top.sv
tb/tb_mem_region.sv

/* run.sh */
#!/bin/sh
# compile the memory region testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_mem_region \
  -f flist.f \
  -Mdir obj_dir

./obj_dir/Vtb_mem_region

/* tb/tb_mem_region.sv */
//************************************************
// testbench for the local memory region; random
// core and APB traffic from a fixed seed, checked
// against a word model with byte-enable writes
//************************************************

`timescale 1ns/10ps

module tb_mem_region;

  localparam int WAIT_LIMIT  = 64;
  localparam int TOTAL_WORDS = mem_region_pkg::NUM_BANKS * mem_region_pkg::BANK_WORDS;

  logic                              clk;
  logic                              rst_n;
  logic                              lsu_req;
  logic [mem_region_pkg::ADDR_W-1:0] lsu_addr;
  logic                              lsu_we;
  mem_region_pkg::be_t               lsu_be;
  mem_region_pkg::word_t             lsu_wdata;
  logic                              lsu_gnt;
  logic                              lsu_rvalid;
  mem_region_pkg::word_t             lsu_rdata;
  logic                              lsu_err;
  logic                              psel;
  logic                              penable;
  logic                              pwrite;
  logic [mem_region_pkg::ADDR_W-1:0] paddr;
  mem_region_pkg::word_t             pwdata;
  mem_region_pkg::be_t               pstrb;
  logic                              pready;
  mem_region_pkg::word_t             prdata;
  logic                              pslverr;

  // reference copy of both banks indexed by byte address bits 12:2
  mem_region_pkg::word_t model [TOTAL_WORDS];

  mem_region_top UUT (
    .clk          ( clk        ),
    .rst_n        ( rst_n      ),
    .lsu_req_i    ( lsu_req    ),
    .lsu_gnt_o    ( lsu_gnt    ),
    .lsu_addr_i   ( lsu_addr   ),
    .lsu_we_i     ( lsu_we     ),
    .lsu_be_i     ( lsu_be     ),
    .lsu_wdata_i  ( lsu_wdata  ),
    .lsu_rvalid_o ( lsu_rvalid ),
    .lsu_rdata_o  ( lsu_rdata  ),
    .lsu_err_o    ( lsu_err    ),
    .psel_i       ( psel       ),
    .penable_i    ( penable    ),
    .pwrite_i     ( pwrite     ),
    .paddr_i      ( paddr      ),
    .pwdata_i     ( pwdata     ),
    .pstrb_i      ( pstrb      ),
    .pready_o     ( pready     ),
    .prdata_o     ( prdata     ),
    .pslverr_o    ( pslverr    )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_word(input string name, input mem_region_pkg::word_t got,
                            input mem_region_pkg::word_t exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "bit mismatch");
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "count mismatch");
    end
  endtask

  task automatic report_hang(input string what);
    $display("Timeout at %0t: %s never arrived", $time, what);
    $display("TESTBENCH FAILED");
    $fatal(1, "handshake timeout");
  endtask

  function automatic mem_region_pkg::word_t merge_bytes(input mem_region_pkg::word_t old_w,
                                                        input mem_region_pkg::word_t new_w,
                                                        input mem_region_pkg::be_t be);
    mem_region_pkg::word_t res;
    res = old_w;
    for (int b = 0; b < mem_region_pkg::BE_W; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // preload pattern in which every index bit shows up
  function automatic mem_region_pkg::word_t fill_word(input int idx);
    return mem_region_pkg::word_t'(idx * 32'h0001_0003) ^ 32'hc3a5_0f0f;
  endfunction

  function automatic logic [31:0] core_addr(input logic in_region);
    logic [31:0] r;
    r = $urandom();
    if (in_region) begin
      return {12'h001, 7'h00, r[12:2], 2'b00};
    end
    if (r[31:20] == mem_region_pkg::REGION_TAG) begin
      r[31] = 1'b1;
    end
    return r;
  endfunction

  function automatic logic [31:0] apb_addr(input logic in_region);
    logic [31:0] r;
    r = $urandom();
    if (in_region) begin
      return {19'h0, r[12:2], 2'b00};
    end
    return 32'(mem_region_pkg::REGION_BYTES) + {16'h0, r[15:2], 2'b00};
  endfunction

  // starts and ends 1 ns after a rising edge
  task automatic core_access(input logic [31:0] addr, input logic we,
                             input mem_region_pkg::be_t be, input mem_region_pkg::word_t wdata,
                             output int gnt_wait, output time done_t);
    logic                  local_hit;
    logic [10:0]           idx;
    mem_region_pkg::word_t exp;
    int                    n;
    local_hit = (addr[31:20] == mem_region_pkg::REGION_TAG);
    idx       = addr[12:2];
    lsu_req   = 1'b1;
    lsu_addr  = addr;
    lsu_we    = we;
    lsu_be    = be;
    lsu_wdata = wdata;
    gnt_wait  = 0;
    @(negedge clk);
    while (!lsu_gnt) begin
      gnt_wait++;
      if (gnt_wait > WAIT_LIMIT) report_hang("lsu_gnt_o");
      @(negedge clk);
    end
    // access takes place at the coming edge
    exp = model[idx];
    if (local_hit && we) begin
      model[idx] = merge_bytes(model[idx], wdata, be);
    end
    if (!local_hit) check_count("lsu_gnt_o wait outside region", gnt_wait, 0);
    @(posedge clk);
    #1;
    lsu_req = 1'b0;
    n = 1;
    @(negedge clk);
    while (!lsu_rvalid) begin
      n++;
      if (n > WAIT_LIMIT) report_hang("lsu_rvalid_o");
      @(negedge clk);
    end
    check_count("lsu_rvalid_o cycles after grant", n, 1);
    check_bit("lsu_err_o", lsu_err, !local_hit);
    if (!local_hit) begin
      check_word("lsu_rdata_o", lsu_rdata, '0);
    end else if (!we) begin
      check_word("lsu_rdata_o", lsu_rdata, exp);
    end
    done_t = $time;
    @(posedge clk);
    #1;
  endtask

  task automatic apb_transfer(input logic [31:0] addr, input logic wr,
                              input mem_region_pkg::be_t strb, input mem_region_pkg::word_t wdata,
                              output time done_t);
    logic                  in_range;
    logic [10:0]           idx;
    mem_region_pkg::word_t exp;
    int                    n;
    in_range = (addr < mem_region_pkg::REGION_BYTES);
    idx      = addr[12:2];
    exp      = '0;
    psel     = 1'b1;
    penable  = 1'b0;
    pwrite   = wr;
    paddr    = addr;
    pwdata   = wdata;
    pstrb    = strb;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    n = 1;
    // first access cycle owns the bank
    if (in_range) begin
      exp = model[idx];
      if (wr) model[idx] = merge_bytes(model[idx], wdata, strb);
    end
    while (!pready) begin
      n++;
      if (n > WAIT_LIMIT) report_hang("pready_o");
      @(negedge clk);
    end
    check_count("pready_o access cycle", n, in_range ? 2 : 1);
    check_bit("pslverr_o", pslverr, !in_range);
    if (in_range && !wr) check_word("prdata_o", prdata, exp);
    done_t = $time;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // one read per cycle with a new request right after each grant
  task automatic core_burst(input int count);
    logic [31:0]           addrs [$];
    mem_region_pkg::word_t exp_q [$];
    logic [31:0]           a;
    int                    grants;
    int                    resps;
    int                    cycles;
    for (int i = 0; i < count; i++) begin
      a     = core_addr(1'b1);
      a[12] = i[0];
      addrs.push_back(a);
    end
    grants   = 0;
    resps    = 0;
    cycles   = 0;
    lsu_req  = 1'b1;
    lsu_we   = 1'b0;
    lsu_be   = '1;
    lsu_addr = addrs[0];
    while (resps < count) begin
      @(negedge clk);
      cycles++;
      if (cycles > 4 * count + 8) report_hang("burst response");
      if (lsu_rvalid) begin
        check_bit("lsu_rvalid_o matched to a grant", exp_q.size() != 0, 1'b1);
        check_word("lsu_rdata_o in burst", lsu_rdata, exp_q.pop_front());
        check_bit("lsu_err_o in burst", lsu_err, 1'b0);
        resps++;
      end
      if (lsu_req && lsu_gnt) begin
        exp_q.push_back(model[lsu_addr[12:2]]);
        grants++;
      end
      @(posedge clk);
      #1;
      if (grants == count) lsu_req = 1'b0;
      else lsu_addr = addrs[grants];
    end
    @(negedge clk);
    check_bit("lsu_rvalid_o after burst", lsu_rvalid, 1'b0);
    @(posedge clk);
    #1;
  endtask

  initial begin
    repeat (200000) @(posedge clk);
    report_hang("end of the test sequence");
  end

  initial begin
    time                   t_apb;
    time                   t_core;
    int                    gw;
    int                    dly;
    logic [31:0]           r;
    logic [31:0]           a;
    logic [31:0]           ca;
    mem_region_pkg::word_t w1;
    mem_region_pkg::word_t w2;
    void'($urandom(31));
    lsu_req   = 1'b0;
    lsu_addr  = '0;
    lsu_we    = 1'b0;
    lsu_be    = '0;
    lsu_wdata = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    pstrb     = '0;
    rst_n     = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // idle outputs after reset
    repeat (4) begin
      @(negedge clk);
      check_bit("lsu_rvalid_o", lsu_rvalid, 1'b0);
      check_bit("lsu_err_o", lsu_err, 1'b0);
      check_bit("pready_o", pready, 1'b0);
      check_bit("pslverr_o", pslverr, 1'b0);
    end
    @(posedge clk);
    #1;

    for (int i = 0; i < TOTAL_WORDS; i++) begin
      core_access({12'h001, 7'h00, i[10:0], 2'b00}, 1'b1, 4'hf, fill_word(i), gw, t_core);
    end

    // partial core writes and read-back
    repeat (8) begin
      a = core_addr(1'b1);
      r = $urandom();
      core_access(a, 1'b1, r[3:0], $urandom(), gw, t_core);
      core_access(a, 1'b0, 4'hf, '0, gw, t_core);
    end

    // error path leaves the matching local word alone
    repeat (4) begin
      a = core_addr(1'b0);
      core_access(a, 1'b1, 4'hf, $urandom(), gw, t_core);
      core_access(a, 1'b0, 4'hf, '0, gw, t_core);
      core_access({12'h001, 7'h00, a[12:2], 2'b00}, 1'b0, 4'hf, '0, gw, t_core);
    end

    repeat (6) begin
      a = apb_addr(1'b1);
      r = $urandom();
      apb_transfer(a, 1'b1, r[3:0], $urandom(), t_apb);
      apb_transfer(a, 1'b0, 4'h0, '0, t_apb);
      core_access({12'h001, 7'h00, a[12:2], 2'b00}, 1'b0, 4'hf, '0, gw, t_core);
      apb_transfer(apb_addr(1'b0), r[4], 4'hf, $urandom(), t_apb);
    end

    // core request lands on the host's first access cycle in the same bank
    repeat (6) begin
      a  = apb_addr(1'b1);
      r  = $urandom();
      w1 = $urandom();
      w2 = $urandom();
      ca = {12'h001, 7'h00, a[12], r[11:2], 2'b00};
      fork
        apb_transfer(a, r[0], 4'hf, w1, t_apb);
        begin
          @(posedge clk);
          #1;
          core_access(ca, r[1], r[15:12], w2, gw, t_core);
        end
      join
      check_bit("lsu_gnt_o held behind host", gw > 0, 1'b1);
      check_bit("pready_o before lsu_rvalid_o", t_apb < t_core, 1'b1);
      core_access({12'h001, 7'h00, a[12:2], 2'b00}, 1'b0, 4'hf, '0, gw, t_core);
      core_access(ca, 1'b0, 4'hf, '0, gw, t_core);
    end

    core_burst(16);

    repeat (300) begin
      r   = $urandom();
      w1  = $urandom();
      w2  = $urandom();
      ca  = core_addr(r[14:12] != 3'd0);
      a   = apb_addr(r[18:16] != 3'd0);
      dly = $urandom_range(2, 0);
      case (r[1:0])
        2'd0: core_access(ca, r[2], r[7:4], w1, gw, t_core);
        2'd1: apb_transfer(a, r[3], r[11:8], w2, t_apb);
        default: begin
          fork
            apb_transfer(a, r[3], r[11:8], w2, t_apb);
            begin
              repeat (dly) begin
                @(posedge clk);
                #1;
              end
              core_access(ca, r[2], r[7:4], w1, gw, t_core);
            end
          join
        end
      endcase
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* src/mem_region_top.sv */
//************************************************
// local memory region top; core load/store port and
// APB host port sharing two byte-addressable banks
//************************************************

`timescale 1ns/10ps

module mem_region_top (
  input  logic                              clk,
  input  logic                              rst_n,
  // core load/store port
  input  logic                              lsu_req_i,
  output logic                              lsu_gnt_o,
  input  logic [mem_region_pkg::ADDR_W-1:0] lsu_addr_i,
  input  logic                              lsu_we_i,
  input  mem_region_pkg::be_t               lsu_be_i,
  input  mem_region_pkg::word_t             lsu_wdata_i,
  output logic                              lsu_rvalid_o,
  output mem_region_pkg::word_t             lsu_rdata_o,
  output logic                              lsu_err_o,
  // APB host port
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [mem_region_pkg::ADDR_W-1:0] paddr_i,
  input  mem_region_pkg::word_t             pwdata_i,
  input  mem_region_pkg::be_t               pstrb_i,
  output logic                              pready_o,
  output mem_region_pkg::word_t             prdata_o,
  output logic                              pslverr_o
);

  // core side towards the banks
  logic [mem_region_pkg::NUM_BANKS-1:0]                  core_req;
  logic [mem_region_pkg::NUM_BANKS-1:0]                  core_gnt;
  logic                                                  core_we;
  mem_region_pkg::be_t                                   core_be;
  mem_region_pkg::word_addr_t                            core_addr;
  mem_region_pkg::word_t                                 core_wdata;
  logic                                                  err_grant;

  // host side towards the banks
  logic [mem_region_pkg::NUM_BANKS-1:0]                  host_req;
  logic                                                  host_we;
  mem_region_pkg::be_t                                   host_be;
  mem_region_pkg::word_addr_t                            host_addr;
  mem_region_pkg::word_t                                 host_wdata;

  // bank responses
  logic [mem_region_pkg::NUM_BANKS-1:0]                  bank_rvalid;
  mem_region_pkg::word_t [mem_region_pkg::NUM_BANKS-1:0] bank_rdata;

  lsu_req_decoder u_decoder (
    .clk          ( clk         ),
    .rst_n        ( rst_n       ),
    .lsu_req_i    ( lsu_req_i   ),
    .lsu_we_i     ( lsu_we_i    ),
    .lsu_addr_i   ( lsu_addr_i  ),
    .lsu_be_i     ( lsu_be_i    ),
    .lsu_wdata_i  ( lsu_wdata_i ),
    .bank_gnt_i   ( core_gnt    ),
    .lsu_gnt_o    ( lsu_gnt_o   ),
    .bank_req_o   ( core_req    ),
    .bank_we_o    ( core_we     ),
    .bank_be_o    ( core_be     ),
    .bank_addr_o  ( core_addr   ),
    .bank_wdata_o ( core_wdata  ),
    .err_grant_o  ( err_grant   )
  );

  apb_bank_bridge u_apb_bridge (
    .clk          ( clk        ),
    .rst_n        ( rst_n      ),
    .psel_i       ( psel_i     ),
    .penable_i    ( penable_i  ),
    .pwrite_i     ( pwrite_i   ),
    .paddr_i      ( paddr_i    ),
    .pwdata_i     ( pwdata_i   ),
    .pstrb_i      ( pstrb_i    ),
    .bank_rdata_i ( bank_rdata ),
    .pready_o     ( pready_o   ),
    .pslverr_o    ( pslverr_o  ),
    .prdata_o     ( prdata_o   ),
    .host_req_o   ( host_req   ),
    .host_we_o    ( host_we    ),
    .host_be_o    ( host_be    ),
    .host_addr_o  ( host_addr  ),
    .host_wdata_o ( host_wdata )
  );

  for (genvar b = 0; b < mem_region_pkg::NUM_BANKS; b++) begin : g_bank
    mem_bank u_bank (
      .clk           ( clk            ),
      .rst_n         ( rst_n          ),
      .host_req_i    ( host_req[b]    ),
      .host_we_i     ( host_we        ),
      .host_be_i     ( host_be        ),
      .host_addr_i   ( host_addr      ),
      .host_wdata_i  ( host_wdata     ),
      .core_req_i    ( core_req[b]    ),
      .core_we_i     ( core_we        ),
      .core_be_i     ( core_be        ),
      .core_addr_i   ( core_addr      ),
      .core_wdata_i  ( core_wdata     ),
      .core_gnt_o    ( core_gnt[b]    ),
      .core_rvalid_o ( bank_rvalid[b] ),
      .rdata_o       ( bank_rdata[b]  )
    );
  end

  lsu_resp_merger u_merger (
    .clk           ( clk          ),
    .rst_n         ( rst_n        ),
    .bank_rvalid_i ( bank_rvalid  ),
    .bank_rdata_i  ( bank_rdata   ),
    .err_grant_i   ( err_grant    ),
    .lsu_rvalid_o  ( lsu_rvalid_o ),
    .lsu_err_o     ( lsu_err_o    ),
    .lsu_rdata_o   ( lsu_rdata_o  )
  );

endmodule

/* src/lsu_resp_merger.sv */
//************************************************
// merges bank responses and the error response back
// onto the core response channel
//************************************************

`timescale 1ns/10ps

module lsu_resp_merger (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic [mem_region_pkg::NUM_BANKS-1:0]                  bank_rvalid_i,
  input  mem_region_pkg::word_t [mem_region_pkg::NUM_BANKS-1:0] bank_rdata_i,
  input  logic                                                  err_grant_i,
  output logic                                                  lsu_rvalid_o,
  output logic                                                  lsu_err_o,
  output mem_region_pkg::word_t                                 lsu_rdata_o
);

  logic err_q;

  // error response lands one cycle after its grant as a bank response does
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else begin
      err_q <= err_grant_i;
    end
  end

  assign lsu_rvalid_o = (|bank_rvalid_i) | err_q;
  assign lsu_err_o    = err_q;

  // zero data unless a bank answers
  always_comb begin
    lsu_rdata_o = '0;
    for (int b = 0; b < mem_region_pkg::NUM_BANKS; b++) begin
      if (bank_rvalid_i[b]) begin
        lsu_rdata_o = bank_rdata_i[b];
      end
    end
  end

  // banks and error path never answer together
  a_single_resp_source : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0({bank_rvalid_i, err_q})
  ) else $error("more than one response source active");

endmodule

/* src/apb_bank_bridge.sv */
//************************************************
// APB slave for host access to the banks; in-range
// transfers take three cycles, out-of-range ones
// end with pslverr in the first access cycle
//************************************************

`timescale 1ns/10ps

module apb_bank_bridge (
  input  logic                                                          clk,
  input  logic                                                          rst_n,
  input  logic                                                          psel_i,
  input  logic                                                          penable_i,
  input  logic                                                          pwrite_i,
  input  logic [mem_region_pkg::ADDR_W-1:0]                             paddr_i,
  input  mem_region_pkg::word_t                                         pwdata_i,
  input  mem_region_pkg::be_t                                           pstrb_i,
  input  mem_region_pkg::word_t [mem_region_pkg::NUM_BANKS-1:0]         bank_rdata_i,
  output logic                                                          pready_o,
  output logic                                                          pslverr_o,
  output mem_region_pkg::word_t                                         prdata_o,
  output logic [mem_region_pkg::NUM_BANKS-1:0]                          host_req_o,
  output logic                                                          host_we_o,
  output mem_region_pkg::be_t                                           host_be_o,
  output mem_region_pkg::word_addr_t                                    host_addr_o,
  output mem_region_pkg::word_t                                         host_wdata_o
);

  logic                      first_access;
  logic                      in_range;
  logic                      pend_q;
  mem_region_pkg::bank_idx_t bank_sel;
  mem_region_pkg::bank_idx_t bank_q;

  // pend_q marks the second access cycle of an in-range transfer
  assign first_access = psel_i & penable_i & ~pend_q;
  assign in_range     = (paddr_i < mem_region_pkg::REGION_BYTES);
  assign bank_sel     = paddr_i[mem_region_pkg::BANK_SEL_BIT];

  always_comb begin
    host_req_o = '0;
    if (first_access && in_range) begin
      host_req_o[bank_sel] = 1'b1;
    end
  end

  // reads fetch the whole word
  assign host_we_o    = pwrite_i;
  assign host_be_o    = pwrite_i ? pstrb_i : '1;
  assign host_addr_o  = paddr_i[mem_region_pkg::BANK_SEL_BIT-1:2];
  assign host_wdata_o = pwdata_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= 1'b0;
      bank_q <= '0;
    end else begin
      pend_q <= first_access & in_range;
      if (first_access && in_range) begin
        bank_q <= bank_sel;
      end
    end
  end

  // completion and read data
  assign pready_o  = pend_q | (first_access & ~in_range);
  assign pslverr_o = first_access & ~in_range;
  assign prdata_o  = pend_q ? bank_rdata_i[bank_q] : '0;

  // every access cycle follows a cycle with psel set
  a_penable_needs_psel : assert property (
    @(posedge clk) disable iff (!rst_n)
    penable_i |-> psel_i && $past(psel_i)
  ) else $error("APB access cycle without setup");

endmodule

/* src/mem_bank.sv */
//************************************************
// single RAM bank with byte-enable writes and a
// registered read; the host port always wins over
// the core port
//************************************************

`timescale 1ns/10ps

module mem_bank (
  input  logic                       clk,
  input  logic                       rst_n,
  // host side, from the APB bridge
  input  logic                       host_req_i,
  input  logic                       host_we_i,
  input  mem_region_pkg::be_t        host_be_i,
  input  mem_region_pkg::word_addr_t host_addr_i,
  input  mem_region_pkg::word_t      host_wdata_i,
  // core side, from the request decoder
  input  logic                       core_req_i,
  input  logic                       core_we_i,
  input  mem_region_pkg::be_t        core_be_i,
  input  mem_region_pkg::word_addr_t core_addr_i,
  input  mem_region_pkg::word_t      core_wdata_i,
  output logic                       core_gnt_o,
  output logic                       core_rvalid_o,
  output mem_region_pkg::word_t      rdata_o
);

  mem_region_pkg::word_t      mem_q [mem_region_pkg::BANK_WORDS];
  mem_region_pkg::word_t      rdata_q;
  logic                       rvalid_q;

  // selected access after arbitration
  logic                       acc_en;
  logic                       acc_we;
  mem_region_pkg::be_t        acc_be;
  mem_region_pkg::word_addr_t acc_addr;
  mem_region_pkg::word_t      acc_wdata;

  // fixed priority with the core served only when the host is idle
  assign core_gnt_o = core_req_i & ~host_req_i;

  always_comb begin
    if (host_req_i) begin
      acc_we    = host_we_i;
      acc_be    = host_be_i;
      acc_addr  = host_addr_i;
      acc_wdata = host_wdata_i;
    end else begin
      acc_we    = core_we_i;
      acc_be    = core_be_i;
      acc_addr  = core_addr_i;
      acc_wdata = core_wdata_i;
    end
  end

  assign acc_en = host_req_i | core_gnt_o;

  // storage array and read register
  always_ff @(posedge clk) begin
    if (acc_en) begin
      if (acc_we) begin
        for (int b = 0; b < mem_region_pkg::BE_W; b++) begin
          if (acc_be[b]) begin
            mem_q[acc_addr][b*8 +: 8] <= acc_wdata[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[acc_addr];
      end
    end
  end

  // response strobe for the core side only
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= core_gnt_o;
    end
  end

  assign core_rvalid_o = rvalid_q;
  assign rdata_o       = rdata_q;

  // host requests are single-cycle pulses so a core stall lasts one cycle
  a_host_req_pulse : assert property (
    @(posedge clk) disable iff (!rst_n)
    host_req_i |=> !host_req_i
  ) else $error("host held the bank for more than one cycle");

endmodule

/* src/lsu_req_decoder.sv */
//************************************************
// core load/store request decoder; steers a request
// to its bank or grants it at once on the error path
//************************************************

`timescale 1ns/10ps

module lsu_req_decoder (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      lsu_req_i,
  input  logic                                      lsu_we_i,
  input  logic [mem_region_pkg::ADDR_W-1:0]         lsu_addr_i,
  input  mem_region_pkg::be_t                       lsu_be_i,
  input  mem_region_pkg::word_t                     lsu_wdata_i,
  input  logic [mem_region_pkg::NUM_BANKS-1:0]      bank_gnt_i,
  output logic                                      lsu_gnt_o,
  output logic [mem_region_pkg::NUM_BANKS-1:0]      bank_req_o,
  output logic                                      bank_we_o,
  output mem_region_pkg::be_t                       bank_be_o,
  output mem_region_pkg::word_addr_t                bank_addr_o,
  output mem_region_pkg::word_t                     bank_wdata_o,
  output logic                                      err_grant_o
);

  logic                      in_region;
  mem_region_pkg::bank_idx_t bank_sel;

  // tag compare and bank pick
  assign in_region = (lsu_addr_i[mem_region_pkg::REGION_TAG_HI:mem_region_pkg::REGION_TAG_LO]
                      == mem_region_pkg::REGION_TAG);
  assign bank_sel  = lsu_addr_i[mem_region_pkg::BANK_SEL_BIT];

  always_comb begin
    bank_req_o = '0;
    if (lsu_req_i && in_region) begin
      bank_req_o[bank_sel] = 1'b1;
    end
  end

  // payload is shared by both banks and only the request is steered
  assign bank_we_o    = lsu_we_i;
  assign bank_be_o    = lsu_be_i;
  assign bank_addr_o  = lsu_addr_i[mem_region_pkg::BANK_SEL_BIT-1:2];
  assign bank_wdata_o = lsu_wdata_i;

  // outside the region the error path never stalls
  assign lsu_gnt_o   = in_region ? bank_gnt_i[bank_sel] : lsu_req_i;
  assign err_grant_o = lsu_req_i & ~in_region;

  // a stalled request stays up with the same address
  a_req_held_until_gnt : assert property (
    @(posedge clk) disable iff (!rst_n)
    lsu_req_i && !lsu_gnt_o |=> lsu_req_i && $stable(lsu_addr_i)
  ) else $error("core request dropped or moved before its grant");

endmodule

/* src/mem_region_pkg.sv */
//************************************************
// address map, widths and bank count of the local
// memory region; modules refer to these by scoped
// names
//************************************************

package mem_region_pkg;

  // word and byte-enable widths of core port, APB and banks
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;

  // core port and paddr width
  localparam int ADDR_W = 32;

  // tag field that marks a local address
  localparam int          REGION_TAG_HI = 31;
  localparam int          REGION_TAG_LO = 20;
  localparam logic [11:0] REGION_TAG    = 12'h001;

  // bank organisation
  localparam int NUM_BANKS    = 2;
  localparam int BANK_WORDS   = 1024;
  localparam int BANK_AW      = 10;
  localparam int BANK_SEL_BIT = 12;

  // total bytes in the region for the APB range check
  localparam int unsigned REGION_BYTES = NUM_BANKS * BANK_WORDS * BE_W;

  // bank number
  typedef logic [0:0] bank_idx_t;

  // one data word
  typedef logic [DATA_W-1:0] word_t;

  // byte enables of one word
  typedef logic [BE_W-1:0] be_t;

  // word index inside a bank
  typedef logic [BANK_AW-1:0] word_addr_t;

endpackage
